//--- logic/obj_pkg.sv
/*
 * sprite engine shared definitions
 * table geometry, register map, config bits
 * and the draw request carried to the line drawer
 */
`default_nettype none

package obj_pkg;

    // object table geometry
    localparam int obj_count = 128;               // sprite entries
    localparam int obj_bytes = 8;                 // bytes per entry
    localparam int tbl_aw    = 10;                // table and buffer address width
    localparam int slot_w    = $clog2(obj_count); // entry index width
    localparam int sub_w     = $clog2(obj_bytes); // byte index width

    // register map
    localparam logic [tbl_aw-1:0] reg_cfg = '0;

    // config register bits
    localparam int         cfg_irq_en = 0;  // vertical blank interrupt enable
    localparam int         cfg_obj_en = 4;  // table copy enable
    localparam logic [7:0] cfg_reset  = 8'h10;

    /*
     * entry layout
     * b0 active, priority   b1 size, code[12:8]   b2 code[7:0]   b3 attr
     * b4 vflip, y[8]        b5 y[7:0]             b6 hflip, x[8] b7 x[7:0]
     * sizes 4..7 behave as size 3
     */

    // one request per 16 pixel column of a sprite on the current line
    typedef struct packed {
        logic [12:0] code;
        logic [7:0]  attr;
        logic        hflip;
        logic        vflip;
        logic [8:0]  xpos;
        logic [3:0]  ysub;   // row inside the tile
    } draw_req_t;

endpackage

`default_nettype wire

//--- logic/obj_dual_ram.sv
/*
 * 1024x8 RAM, one write port and two registered read ports
 * used for the object table and the priority buffer
 */
`default_nettype none
`timescale 1ns/1ps

module obj_dual_ram import obj_pkg::*; (
    input  wire              clk,
    input  wire              we,
    input  wire [tbl_aw-1:0] waddr,
    input  wire [7:0]        wdata,
    input  wire [tbl_aw-1:0] raddr_a,
    input  wire [tbl_aw-1:0] raddr_b,
    output logic [7:0]       rdata_a,
    output logic [7:0]       rdata_b
);

    logic [7:0] mem [0:(1<<tbl_aw)-1];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read ports return the old byte on a same-address write
    always_ff @(posedge clk) begin
        rdata_a <= mem[raddr_a];
        rdata_b <= mem[raddr_b];
    end

endmodule

`default_nettype wire

//--- logic/obj_regs.sv
/*
 * CPU register decode for the sprite engine
 * config register, status read-back, vertical blank interrupt
 */
`default_nettype none
`timescale 1ns/1ps

module obj_regs import obj_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        cs,
    input  wire        cpu_we,
    input  wire [10:0] cpu_addr,
    input  wire [7:0]  cpu_dout,
    input  wire        lvbl,
    input  wire        dma_busy,
    output logic [7:0] reg_dout,
    output logic       reg_sel,
    output logic       obj_en,
    output logic       irq_n
);

    logic [7:0] cfg;
    logic       lvbl_l;
    logic       reg_acc;
    logic       cfg_hit;
    logic       irq_en;

    assign reg_acc = cs & ~cpu_addr[10];       // register half of the map
    assign cfg_hit = cpu_addr[tbl_aw-1:0] == reg_cfg;
    assign irq_en  = cfg[cfg_irq_en];
    assign obj_en  = cfg[cfg_obj_en];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg     <= cfg_reset;
            lvbl_l  <= 1'b0;
            irq_n   <= 1'b1;
            reg_sel <= 1'b0;
        end else begin
            lvbl_l  <= lvbl;
            reg_sel <= reg_acc & ~cpu_we;      // steers cpu_din on the next cycle
            if (reg_acc && cpu_we && cfg_hit) begin
                cfg <= cpu_dout;
            end
            // interrupt held until the enable is cleared
            if (!irq_en) begin
                irq_n <= 1'b1;
            end else if (lvbl_l && !lvbl) begin
                irq_n <= 1'b0;                 // start of vertical blank
            end
        end
    end

    // status byte, only bit 0 is defined
    always_ff @(posedge clk) begin
        if (reg_acc && !cpu_we) begin
            reg_dout <= cfg_hit ? {7'd0, dma_busy} : 8'd0;
        end
    end

endmodule

`default_nettype wire

//--- logic/obj_dma.sv
/*
 * vertical blank copy engine
 * clears the priority buffer, then copies active table entries
 * into the buffer slot given by their priority byte
 */
`default_nettype none
`timescale 1ns/1ps

module obj_dma import obj_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               lvbl,
    input  wire               obj_en,
    input  wire  [7:0]        tbl_data,
    output logic [tbl_aw-1:0] tbl_addr,
    output logic              buf_we,
    output logic [tbl_aw-1:0] buf_addr,
    output logic [7:0]        buf_data,
    output logic              dma_busy
);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_clear = 2'd1;
    localparam logic [1:0] st_copy  = 2'd2;

    logic [1:0]        state;
    logic              lvbl_l;
    logic [tbl_aw-1:0] rd_addr;    // clear counter, then table read address
    logic [tbl_aw-1:0] a_d;        // address of the byte now on tbl_data
    logic              iss;        // table reads still being issued
    logic              v_d;        // tbl_data holds a wanted byte
    logic [slot_w-1:0] prio;
    logic [tbl_aw:0]   rd_next;
    logic [tbl_aw:0]   skip_next;
    logic              first;
    logic              skip;
    logic              clearing;

    assign rd_next   = {1'b0, rd_addr} + 1'b1;
    assign skip_next = {1'b0, a_d[tbl_aw-1:sub_w], {sub_w{1'b0}}} + (tbl_aw+1)'(obj_bytes);
    assign first     = a_d[sub_w-1:0] == '0;
    assign skip      = (state == st_copy) & v_d & first & ~tbl_data[7];
    assign clearing  = state == st_clear;

    assign dma_busy = state != st_idle;
    assign tbl_addr = rd_addr;
    // b0 of an entry routes itself, later bytes use the stored priority
    assign buf_we   = clearing | ((state == st_copy) & v_d & (~first | tbl_data[7]));
    assign buf_addr = clearing ? rd_addr
                               : {(first ? tbl_data[slot_w-1:0] : prio), a_d[sub_w-1:0]};
    assign buf_data = clearing ? 8'd0 : tbl_data;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            lvbl_l  <= 1'b0;
            rd_addr <= '0;
            iss     <= 1'b0;
            v_d     <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            case (state)
                st_idle: begin
                    if (lvbl_l && !lvbl && obj_en) begin
                        state   <= st_clear;
                        rd_addr <= '0;
                    end
                end
                st_clear: begin
                    rd_addr <= rd_next[tbl_aw-1:0];
                    if (rd_next[tbl_aw]) begin  // wrapped back to 0
                        state <= st_copy;
                        iss   <= 1'b1;
                    end
                end
                st_copy: begin
                    v_d <= iss;
                    if (iss) begin
                        rd_addr <= rd_next[tbl_aw-1:0];
                        if (rd_next[tbl_aw]) begin
                            iss <= 1'b0;       // last table byte issued
                        end
                    end
                    // inactive entry, drop the byte in flight and jump ahead
                    if (skip) begin
                        rd_addr <= skip_next[tbl_aw-1:0];
                        iss     <= ~skip_next[tbl_aw];
                        v_d     <= 1'b0;
                    end
                    if (!iss && !v_d) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        a_d <= rd_addr;
        if (v_d && first) begin
            prio <= tbl_data[slot_w-1:0];
        end
    end

endmodule

`default_nettype wire

//--- logic/obj_scan.sv
/*
 * line scanner
 * walks the priority buffer each line, tests sprites against it
 * and issues one four-phase draw request per 16 pixel column
 */
`default_nettype none
`timescale 1ns/1ps

module obj_scan import obj_pkg::*; #(
    parameter int line_first = 16
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               hs,
    input  wire               lvbl,
    input  wire  [8:0]        vdump,
    input  wire  [7:0]        buf_data,
    input  wire               draw_ack,
    output logic [tbl_aw-1:0] buf_addr,
    output logic              draw_req,
    output draw_req_t         draw
);

    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_read = 3'd1;   // fetch b0..b7
    localparam logic [2:0] st_req  = 3'd2;   // raise draw_req
    localparam logic [2:0] st_ackw = 3'd3;   // wait for draw_ack high
    localparam logic [2:0] st_relw = 3'd4;   // wait for draw_ack low

    logic [2:0]        state;
    logic              hs_l;
    logic [8:0]        line_l;
    logic [slot_w-1:0] slot;
    logic [sub_w:0]    sub;
    logic [2:0]        col;

    // entry fields
    logic [1:0]        s;
    logic [12:0]       code_base;
    logic [7:0]        attr;
    logic              vflip;
    logic              hflip;
    logic [8:0]        y;
    logic [8:0]        x;

    logic [2:0]        mask;
    logic [8:0]        dy;
    logic              in_zone;
    logic [2:0]        row;
    logic [2:0]        kcol;
    logic [12:0]       code_n;
    logic              last_col;
    logic              last_slot;
    logic              start;
    logic              at_b0;
    logic              at_b7;
    logic              next_slot;

    assign buf_addr = {slot, sub[sub_w-1:0]};

    assign mask     = 3'((4'd1 << s) - 4'd1);      // tiles per side minus one
    assign dy       = line_l - y;                  // wraps mod 512
    assign in_zone  = (dy >> (3'd4 + 3'(s))) == 9'd0;
    assign row      = dy[6:4] ^ (vflip ? mask : 3'd0);
    assign kcol     = col ^ (hflip ? mask : 3'd0);
    assign code_n   = code_base + (13'(row) << s) + 13'(kcol);
    assign last_col  = col == mask;
    assign last_slot = slot == slot_w'(obj_count - 1);

    assign start = hs & ~hs_l & lvbl & (state == st_idle) & (vdump >= 9'(line_first));
    assign at_b0 = (state == st_read) & (sub == (sub_w+1)'(1));
    assign at_b7 = (state == st_read) & (sub == (sub_w+1)'(obj_bytes));

    always_comb begin
        next_slot = 1'b0;
        if (at_b0 && !buf_data[7]) begin
            next_slot = 1'b1;                      // inactive slot
        end
        if (at_b7 && !in_zone) begin
            next_slot = 1'b1;
        end
        if (state == st_relw && !draw_ack && last_col) begin
            next_slot = 1'b1;                      // all columns sent
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            hs_l     <= 1'b0;
            slot     <= '0;
            sub      <= '0;
            col      <= '0;
            draw_req <= 1'b0;
        end else begin
            hs_l <= hs;
            case (state)
                st_idle: begin
                    if (start) begin
                        slot  <= '0;
                        sub   <= '0;
                        state <= st_read;
                    end
                end
                st_read: begin
                    sub <= sub + 1'b1;
                    if (at_b7 && in_zone) begin
                        col   <= '0;
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (!draw_ack) begin
                        draw_req <= 1'b1;
                        state    <= st_ackw;
                    end
                end
                st_ackw: begin
                    if (draw_ack) begin
                        draw_req <= 1'b0;
                        state    <= st_relw;
                    end
                end
                st_relw: begin
                    if (!draw_ack && !last_col) begin
                        col   <= col + 1'b1;
                        state <= st_req;
                    end
                end
                default: state <= st_idle;
            endcase
            if (next_slot) begin
                sub   <= '0;
                slot  <= slot + 1'b1;
                state <= last_slot ? st_idle : st_read;
            end
        end
    end

    // entry capture, one byte per cycle behind the read address
    always_ff @(posedge clk) begin
        if (start) begin
            line_l <= vdump;
        end
        if (state == st_read) begin
            case (sub)
                4'd2: begin
                    s               <= buf_data[7] ? 2'd3 : buf_data[6:5];
                    code_base[12:8] <= buf_data[4:0];
                end
                4'd3: code_base[7:0] <= buf_data;
                4'd4: attr <= buf_data;
                4'd5: {vflip, y[8]} <= buf_data[1:0];
                4'd6: y[7:0] <= buf_data;
                4'd7: {hflip, x[8]} <= buf_data[1:0];
                4'd8: x[7:0] <= buf_data;
                default: ;
            endcase
        end
        if (state == st_req && !draw_ack) begin   // held while draw_req is high
            draw.code  <= code_n;
            draw.attr  <= attr;
            draw.hflip <= hflip;
            draw.vflip <= vflip;
            draw.xpos  <= x + {2'b00, col, 4'b0000};
            draw.ysub  <= dy[3:0] ^ {4{vflip}};
        end
    end

endmodule

`default_nettype wire

//--- logic/obj_engine.sv
/*
 * sprite engine top level
 * register file, copy engine, table and buffer RAMs, line scanner
 */
`default_nettype none
`timescale 1ns/1ps

module obj_engine import obj_pkg::*; #(
    parameter int line_first = 16
) (
    input  wire        clk,
    input  wire        rst,
    // CPU
    input  wire        cs,
    input  wire        cpu_we,
    input  wire [10:0] cpu_addr,
    input  wire [7:0]  cpu_dout,
    output logic [7:0] cpu_din,
    // video timing
    input  wire [8:0]  vdump,
    input  wire        hs,
    input  wire        lvbl,
    // line drawer
    output logic       draw_req,
    output draw_req_t  draw,
    input  wire        draw_ack,
    output logic       irq_n
);

    logic [7:0]        reg_dout;
    logic              reg_sel;
    logic              obj_en;
    logic              dma_busy;
    logic              tbl_we;
    logic [7:0]        tbl_cpu;     // table byte for CPU reads
    logic [7:0]        tbl_dma;     // table byte for the copy engine
    logic [tbl_aw-1:0] tbl_addr;
    logic              buf_we;
    logic [tbl_aw-1:0] buf_waddr;
    logic [7:0]        buf_wdata;
    logic [tbl_aw-1:0] scan_addr;
    logic [7:0]        scan_data;

    assign tbl_we  = cs & cpu_we & cpu_addr[10];
    assign cpu_din = reg_sel ? reg_dout : tbl_cpu;

    obj_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .cs       (cs),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .lvbl     (lvbl),
        .dma_busy (dma_busy),
        .reg_dout (reg_dout),
        .reg_sel  (reg_sel),
        .obj_en   (obj_en),
        .irq_n    (irq_n)
    );

    obj_dual_ram u_table (
        .clk     (clk),
        .we      (tbl_we),
        .waddr   (cpu_addr[tbl_aw-1:0]),
        .wdata   (cpu_dout),
        .raddr_a (cpu_addr[tbl_aw-1:0]),
        .raddr_b (tbl_addr),
        .rdata_a (tbl_cpu),
        .rdata_b (tbl_dma)
    );

    obj_dma u_dma (
        .clk      (clk),
        .rst      (rst),
        .lvbl     (lvbl),
        .obj_en   (obj_en),
        .tbl_data (tbl_dma),
        .tbl_addr (tbl_addr),
        .buf_we   (buf_we),
        .buf_addr (buf_waddr),
        .buf_data (buf_wdata),
        .dma_busy (dma_busy)
    );

    // second read port of the buffer is idle
    obj_dual_ram u_buffer (
        .clk     (clk),
        .we      (buf_we),
        .waddr   (buf_waddr),
        .wdata   (buf_wdata),
        .raddr_a (scan_addr),
        .raddr_b ('0),
        .rdata_a (scan_data),
        .rdata_b ()
    );

    obj_scan #(
        .line_first (line_first)
    ) u_scan (
        .clk      (clk),
        .rst      (rst),
        .hs       (hs),
        .lvbl     (lvbl),
        .vdump    (vdump),
        .buf_data (scan_data),
        .draw_ack (draw_ack),
        .buf_addr (scan_addr),
        .draw_req (draw_req),
        .draw     (draw)
    );

endmodule

`default_nettype wire

//--- tests/tb_obj_model.svh
/*
 * reference model for the sprite engine testbench
 * table and buffer images, vertical blank copy,
 * per-line list of expected draw requests
 */
`ifndef tb_obj_model_svh
`define tb_obj_model_svh

logic [7:0] tbl_mem [0:(1<<tbl_aw)-1];   // what the CPU wrote
logic [7:0] buf_mem [0:(1<<tbl_aw)-1];   // buffer after the last copy
draw_req_t  exp_q [$];                   // requests still owed on this line

// clear, then active entries land in their priority slot, later index wins
function automatic void copy_table();
    int e;
    int n;
    int p;
    for (n = 0; n < (1 << tbl_aw); n++) begin
        buf_mem[n] = 8'd0;
    end
    for (e = 0; e < obj_count; e++) begin
        if (tbl_mem[e * obj_bytes][7]) begin
            p = int'(tbl_mem[e * obj_bytes][6:0]);
            for (n = 0; n < obj_bytes; n++) begin
                buf_mem[p * obj_bytes + n] = tbl_mem[e * obj_bytes + n];
            end
        end
    end
endfunction

// slot order, then column order
task automatic build_line(input int line);
    int slot;
    int base;
    int s;
    int tiles;
    int x;
    int y;
    int dy;
    int r;
    int ys;
    int c;
    int k;
    int code;
    logic vf;
    logic hf;
    draw_req_t q;
    for (slot = 0; slot < obj_count; slot++) begin
        base = slot * obj_bytes;
        s = int'(buf_mem[base + 1][7:5]);
        if (s > 3) begin
            s = 3;                                  // sizes 4..7 act as 3
        end
        tiles = 1 << s;
        y = int'({buf_mem[base + 4][0], buf_mem[base + 5]});
        dy = (line - y + 512) % 512;
        if (buf_mem[base][7] && dy < 16 * tiles) begin
            vf = buf_mem[base + 4][1];
            hf = buf_mem[base + 6][1];
            x = int'({buf_mem[base + 6][0], buf_mem[base + 7]});
            code = int'({buf_mem[base + 1][4:0], buf_mem[base + 2]});
            r = vf ? tiles - 1 - dy / 16 : dy / 16;
            ys = vf ? 15 - dy % 16 : dy % 16;
            for (c = 0; c < tiles; c++) begin
                k = hf ? tiles - 1 - c : c;
                q.code = 13'((code + r * tiles + k) % 8192);
                q.attr = buf_mem[base + 3];
                q.hflip = hf;
                q.vflip = vf;
                q.xpos = 9'((x + 16 * c) % 512);
                q.ysub = 4'(ys);
                exp_q.push_back(q);
            end
        end
    end
endtask

`endif

//--- tests/tb_obj_engine.sv
/*
 * sprite engine testbench
 * CPU table and register access, frame timing, line drawer responder,
 * request checking against the model, watchdog
 */
`default_nettype none
`timescale 1ns/1ps

module tb_obj_engine import obj_pkg::*; ();

    localparam int line_first   = 16;
    localparam int active_lines = 20;
    localparam int line_len     = 2000;
    localparam int vblank_len   = 2500;
    localparam int frame_cycles = active_lines * line_len + vblank_len;
    localparam int cycle_limit  = 6 * frame_cycles + 6 * frame_cycles / 10;

    logic        clk;
    logic        rst;
    logic        cs;
    logic        cpu_we;
    logic [10:0] cpu_addr;
    logic [7:0]  cpu_dout;
    logic [7:0]  cpu_din;
    logic [8:0]  vdump;
    logic        hs;
    logic        lvbl;
    logic        draw_req;
    draw_req_t   draw;
    logic        draw_ack;
    logic        irq_n;
    integer      seed = 32'hef8a_81ca;
    int          cycles;

    `include "tb_obj_model.svh"

    obj_engine #(
        .line_first (line_first)
    ) obj_engine_i (
        .clk      (clk),
        .rst      (rst),
        .cs       (cs),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_din  (cpu_din),
        .vdump    (vdump),
        .hs       (hs),
        .lvbl     (lvbl),
        .draw_req (draw_req),
        .draw     (draw),
        .draw_ack (draw_ack),
        .irq_n    (irq_n)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s got %0h expected %0h",
                                $time, name, got, exp));
        end
    endtask

    // one CPU write, called just after a falling edge
    task automatic write_byte(input logic [10:0] addr, input logic [7:0] data);
        cs = 1'b1;
        cpu_we = 1'b1;
        cpu_addr = addr;
        cpu_dout = data;
        if (addr[10]) begin
            tbl_mem[addr[9:0]] = data;
        end
        @(negedge clk);
        cs = 1'b0;
        cpu_we = 1'b0;
    endtask

    task automatic read_byte(input logic [10:0] addr, output logic [7:0] data);
        cs = 1'b1;
        cpu_we = 1'b0;
        cpu_addr = addr;
        @(negedge clk);
        cs = 1'b0;
        data = cpu_din;                             // registered read, one cycle
    endtask

    task automatic readback_test(input int count);
        int i;
        logic [10:0] a;
        logic [7:0] got;
        for (i = 0; i < count; i++) begin
            a = 11'h400 | 11'($random(seed));
            write_byte(a, 8'($random(seed)));
            read_byte(a, got);
            check("cpu_din", got, tbl_mem[a[9:0]]);
        end
    endtask

    // every sixth entry active, y spread around line 0 so zones wrap
    task automatic fill_table(input logic [6:0] prio_mask);
        int e;
        int n;
        logic [0:7][7:0] b;
        logic [8:0] y;
        for (e = 0; e < obj_count; e++) begin
            for (n = 0; n < obj_bytes; n++) begin
                b[n] = 8'($random(seed));
            end
            b[0] = {(e % 6) == 0, b[0][6:0] & prio_mask};
            y = 9'(($random(seed) & 127) - 96);
            b[4][0] = y[8];
            b[5] = y[7:0];
            for (n = 0; n < obj_bytes; n++) begin
                write_byte(11'(1024 + e * obj_bytes + n), b[n]);
            end
        end
    endtask

    task automatic run_vblank(input bit copy_on, input bit irq_probe);
        logic [7:0] st;
        int used;
        lvbl = 1'b0;
        vdump = 9'd300;
        repeat (2) @(negedge clk);
        if (irq_probe) begin
            check("irq_n", irq_n, 0);
        end
        read_byte(11'h000, st);
        check("cpu_din status", st, {7'd0, copy_on});
        repeat (2200) @(negedge clk);
        read_byte(11'h000, st);
        check("cpu_din status", st, 0);             // copy finished
        used = 2204;
        if (irq_probe) begin
            write_byte(11'h000, 8'h10);             // interrupt enable off
            @(negedge clk);
            check("irq_n", irq_n, 1);
            used += 2;
        end
        repeat (vblank_len - used) @(negedge clk);
        lvbl = 1'b1;
        if (copy_on) begin
            copy_table();
        end
    endtask

    task automatic run_active();
        int line;
        for (line = line_first; line < line_first + active_lines; line++) begin
            vdump = 9'(line);
            build_line(line);
            hs = 1'b1;
            repeat (8) @(negedge clk);
            hs = 1'b0;
            repeat (line_len - 9) @(negedge clk);
            check("pending requests", exp_q.size(), 0);
            @(negedge clk);
        end
    endtask

    // line drawer, acks after 0..3 cycles and checks each request on arrival
    initial begin : drawer
        draw_req_t held;
        int delay;
        draw_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (draw_req && !draw_ack) begin
                if (exp_q.size() == 0) begin
                    abort_run("draw request arrived when none was expected");
                end
                check("draw", draw, exp_q.pop_front());
                held = draw;
                delay = int'($random(seed) & 3);
                repeat (delay) begin
                    @(negedge clk);
                    check("draw_req", draw_req, 1);
                    check("draw", draw, held);
                end
                draw_ack = 1'b1;
                @(negedge clk);
                while (draw_req) begin
                    check("draw", draw, held);
                    @(negedge clk);
                end
                draw_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        abort_run("timeout: the run did not finish within the cycle limit");
    end

    initial begin : stimulus
        rst = 1'b1;
        cs = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        vdump = '0;
        hs = 1'b0;
        lvbl = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check("irq_n", irq_n, 1);
        check("draw_req", draw_req, 0);
        readback_test(64);
        write_byte(11'h000, 8'h11);                 // objects and interrupt on
        fill_table(7'h0f);                          // many shared priorities
        run_vblank(1'b1, 1'b1);
        run_active();
        fill_table(7'h7f);
        run_vblank(1'b1, 1'b0);
        run_active();
        write_byte(11'h000, 8'h00);                 // copy disabled
        fill_table(7'h3f);
        run_vblank(1'b0, 1'b0);
        run_active();                               // still the old buffer
        write_byte(11'h000, 8'h10);
        run_vblank(1'b1, 1'b0);
        run_active();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+tests
logic/obj_pkg.sv
logic/obj_dual_ram.sv
logic/obj_regs.sv
logic/obj_dma.sv
logic/obj_scan.sv
logic/obj_engine.sv
tests/tb_obj_engine.sv
